// ==== tests/shooter_tests.txt ====
# columns: left right fire frames gap | ship_x missile_x missile_y missile_active enemy_x score
# frames repeats the same keys that many times, expected values hold after the last frame
# ship single steps, both keys, then a long run of left into the clamp at 0
0 0 0  1  0   304   0   0  0    2  0
0 1 0  1  1   308   0   0  0    4  0
1 1 0  1  0   308   0   0  0    6  0
1 0 0  1  2   304   0   0  0    8  0
1 0 0 80  0     0   0   0  0  168  0
# arm, launch from the ship, fire while flying, climb to the ceiling and retire
0 0 1  1  0     0   0   0  0  170  0
0 0 0  1  1     0  14 432  1  172  0
0 0 1  1  0     0  14 424  1  174  0
0 0 0 52  0     0  14   8  1  278  0
0 0 0  1  0     0  14   0  1  280  0
0 0 0  1  3     0   0   0  0  282  0
# move the ship under the enemy's return path while the enemy reaches the right edge
0 1 0 125 0   500   0   0  0  532  0
0 0 0 37  0   500   0   0  0  606  0
0 0 0  1  0   500   0   0  0  608  0
0 0 0  1  0   500   0   0  0  606  0
# second missile meets the enemy on its way left
0 0 1  1  0   500   0   0  0  604  0
0 0 0  1  0   500 514 432  1  602  0
0 0 0 47  0   500 514  56  1  508  0
0 0 0  1  1   500 514  48  1  506  0
0 0 0  1  2   500   0   0  0    0  1
# enemy respawned moving right, ship still answers the keys
0 0 0  1  0   500   0   0  0    2  1
1 0 0  1  0   496   0   0  0    4  1

// ==== files.f ====
verilog/game_pkg.sv
verilog/ship_movement.sv
verilog/missile_movement.sv
verilog/enemy_movement.sv
verilog/hit_scoring.sv
verilog/shooter_top.sv
tests/shooter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the shooter testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module shooter_tb -f files.f -o shooter_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/shooter_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== tests/shooter_tb.sv ====
module shooter_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import game_pkg::*;

    // the hit pulse belongs one cycle after the frame edge, so a few cycles is plenty
    localparam int HIT_TIMEOUT = 8;

    logic                   clk;
    logic                   resetN;
    logic                   start_of_frame;
    logic                   left_key;
    logic                   right_key;
    logic                   fire_key;
    logic [PIXEL_WIDTH-1:0] ship_x;
    logic [PIXEL_WIDTH-1:0] missile_x;
    logic [PIXEL_WIDTH-1:0] missile_y;
    logic [PIXEL_WIDTH-1:0] enemy_x;
    score_t                 score;
    logic                   missile_active;
    logic                   hit;

    // tells an error line which part of the run it came from
    string context_tag;
    int    frames_run;

    shooter_top #(
        .SHIP_STEP     (4),
        .MISSILE_SPEED (512),
        .ENEMY_STEP    (2)
    ) shooter_top_inst (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .left_key       (left_key),
        .right_key      (right_key),
        .fire_key       (fire_key),
        .ship_x         (ship_x),
        .missile_x      (missile_x),
        .missile_y      (missile_y),
        .enemy_x        (enemy_x),
        .score          (score),
        .missile_active (missile_active),
        .hit            (hit)
    );

    // 20 ns clock period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string field, input int got, input int expected);
        assert (got == expected) else begin
            $display("error at %0d ns: %s, %s is %0d, expected %0d",
                     $time, context_tag, field, got, expected);
            $display("Verification failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // keys and the frame pulse go up on the same edge in each frame,
    // then two cycles pass before the outputs are final
    task automatic run_frame(input logic left_in, input logic right_in,
                             input logic fire_in, input bit hit_expected);
        int waited;
        bit seen;
        @(posedge clk);
        left_key       <= left_in;
        right_key      <= right_in;
        fire_key       <= fire_in;
        start_of_frame <= 1'b1;
        @(posedge clk);
        // fire only lasts for the frame edge so an idle missile cannot rearm later
        start_of_frame <= 1'b0;
        fire_key       <= 1'b0;
        if (hit_expected) begin
            waited = 0;
            seen   = 1'b0;
            // each pass looks at hit in the middle of one more cycle after the frame edge
            while (!seen && waited < HIT_TIMEOUT) begin
                @(negedge clk);
                waited++;
                seen = hit;
            end
            if (!seen) begin
                abort_run($sformatf("timeout at %0d ns, %s: no hit pulse after the frame pulse",
                                    $time, context_tag));
            end
            // hit is registered once after the frame edge, so it must show one cycle later
            check_value("hit latency in cycles", waited, 1);
        end else begin
            // the cycle right after the frame edge is where a hit would show
            @(negedge clk);
            check_value("hit", int'(hit), 0);
        end
        // second cycle, where a hit has already reset the missile and the enemy
        @(posedge clk);
        @(negedge clk);
    endtask

    initial begin
        int    fd;
        int    n;
        int    line_no;
        int    prev_score;
        string line;
        int    l_in, r_in, f_in, frames, gap;
        int    exp_ship, exp_mx, exp_my, exp_act, exp_enemy, exp_score;
        bit    hit_expected;

        resetN         = 1'b0;
        start_of_frame = 1'b0;
        left_key       = 1'b0;
        right_key      = 1'b0;
        fire_key       = 1'b0;
        frames_run     = 0;
        prev_score     = 0;
        line_no        = 0;
        context_tag    = "after reset";

        repeat (3) @(posedge clk);
        resetN <= 1'b1;
        @(negedge clk);

        // the ship starts centred on the 640 pixel screen, everything else at the origin
        check_value("ship_x", int'(ship_x), 304);
        check_value("missile_x", int'(missile_x), 0);
        check_value("missile_y", int'(missile_y), 0);
        check_value("missile_active", int'(missile_active), 0);
        check_value("enemy_x", int'(enemy_x), 0);
        check_value("score", int'(score), 0);
        check_value("hit", int'(hit), 0);

        fd = $fopen("tests/shooter_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/shooter_tests.txt for reading");
        end

        while ($fgets(line, fd) != 0) begin
            line_no++;
            // comment and blank lines give no fields at all
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d",
                        l_in, r_in, f_in, frames, gap,
                        exp_ship, exp_mx, exp_my, exp_act, exp_enemy, exp_score);
            if (n == 11) begin
                context_tag = $sformatf("data line %0d", line_no);
                if (frames < 1) begin
                    abort_run($sformatf("data line %0d asks for no frames", line_no));
                end
                for (int i = 0; i < frames; i++) begin
                    // a score step on the last frame of a line means that frame scored a hit
                    hit_expected = (i == frames - 1) && (exp_score != prev_score);
                    run_frame(l_in[0], r_in[0], f_in[0], hit_expected);
                    frames_run++;
                end
                check_value("ship_x", int'(ship_x), exp_ship);
                check_value("missile_x", int'(missile_x), exp_mx);
                check_value("missile_y", int'(missile_y), exp_my);
                check_value("missile_active", int'(missile_active), exp_act);
                check_value("enemy_x", int'(enemy_x), exp_enemy);
                check_value("score", int'(score), exp_score);
                prev_score = exp_score;
                repeat (gap) @(posedge clk);
            end else if (n > 0) begin
                abort_run($sformatf("data line %0d has %0d fields where 11 belong", line_no, n));
            end
        end
        $fclose(fd);

        if (frames_run > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("no frames were read from tests/shooter_tests.txt");
            $display("Verification failed");
            $fatal(1, "simulation stopped");
        end
    end

endmodule

// ==== verilog/shooter_top.sv ====
module shooter_top #(
    parameter int SHIP_STEP     = 4,
    parameter int MISSILE_SPEED = 512,
    parameter int ENEMY_STEP    = 2
) (
    input  logic                             clk,
    input  logic                             resetN,
    input  logic                             start_of_frame,
    input  logic                             left_key,
    input  logic                             right_key,
    input  logic                             fire_key,
    output logic [game_pkg::PIXEL_WIDTH-1:0] ship_x,
    output logic [game_pkg::PIXEL_WIDTH-1:0] missile_x,
    output logic [game_pkg::PIXEL_WIDTH-1:0] missile_y,
    output logic [game_pkg::PIXEL_WIDTH-1:0] enemy_x,
    output game_pkg::score_t                 score,
    output logic                             missile_active,
    output logic                             hit
);

    // the player's ship along the bottom row
    ship_movement #(
        .SHIP_STEP (SHIP_STEP)
    ) ship_movement_inst (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .left_key       (left_key),
        .right_key      (right_key),
        .ship_x         (ship_x)
    );

    // the missile follows the ship until launch, then flies on its own
    missile_movement #(
        .MISSILE_SPEED (MISSILE_SPEED)
    ) missile_movement_inst (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .fire_key       (fire_key),
        .hit            (hit),
        .ship_x         (ship_x),
        .missile_x      (missile_x),
        .missile_y      (missile_y),
        .missile_active (missile_active)
    );

    // a single enemy bouncing between the side edges
    enemy_movement #(
        .ENEMY_STEP (ENEMY_STEP)
    ) enemy_movement_inst (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .hit            (hit),
        .enemy_x        (enemy_x)
    );

    // hit feeds back to both moving objects one cycle after the frame pulse
    hit_scoring hit_scoring_inst (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .missile_x      (missile_x),
        .missile_y      (missile_y),
        .enemy_x        (enemy_x),
        .missile_active (missile_active),
        .hit            (hit),
        .score          (score)
    );

endmodule

// ==== verilog/hit_scoring.sv ====
module hit_scoring (
    input  logic                             clk,
    input  logic                             resetN,
    input  logic                             start_of_frame,
    input  logic [game_pkg::PIXEL_WIDTH-1:0] missile_x,
    input  logic [game_pkg::PIXEL_WIDTH-1:0] missile_y,
    input  logic [game_pkg::PIXEL_WIDTH-1:0] enemy_x,
    input  logic                             missile_active,
    output logic                             hit,
    output game_pkg::score_t                 score
);
    import game_pkg::*;

    // box edges get one more bit than a coordinate so the sums fit
    localparam int CW = PIXEL_WIDTH + 1;

    localparam logic [CW-1:0] ENEMY_TOP    = CW'(ENEMY_Y);
    localparam logic [CW-1:0] ENEMY_BOTTOM = CW'(ENEMY_Y + ENEMY_H);

    // right and bottom edges are exclusive, one past the last pixel
    logic [CW-1:0] m_left;
    logic [CW-1:0] m_right;
    logic [CW-1:0] m_top;
    logic [CW-1:0] m_bottom;
    logic [CW-1:0] e_left;
    logic [CW-1:0] e_right;

    logic overlap_x;
    logic overlap_y;
    logic hit_next;

    assign m_left   = CW'(missile_x);
    assign m_right  = CW'(missile_x) + CW'(MISSILE_W);
    assign m_top    = CW'(missile_y);
    assign m_bottom = CW'(missile_y) + CW'(MISSILE_H);
    assign e_left   = CW'(enemy_x);
    assign e_right  = CW'(enemy_x) + CW'(ENEMY_W);

    // strict compares, so boxes that only share an edge do not collide
    assign overlap_x = (m_left < e_right) && (e_left < m_right);
    assign overlap_y = (m_top < ENEMY_BOTTOM) && (ENEMY_TOP < m_bottom);

    // sampled on the frame edge, before the objects take their new positions
    assign hit_next = start_of_frame && missile_active && overlap_x && overlap_y;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            hit   <= 1'b0;
            score <= '0;
        end else begin
            hit <= hit_next;
            // the score moves on the same edge that raises hit
            if (hit_next && (score != '1)) begin
                score <= score + score_t'(1);
            end
        end
    end

    // frame pulses are spaced apart, so a hit can only ever last one cycle;
    // a longer pulse would knock the enemy back twice
    hit_one_cycle: assert property (
        @(posedge clk) disable iff (!resetN)
        hit |=> !hit
    ) else $error("hit held for more than one cycle");

endmodule

// ==== verilog/enemy_movement.sv ====
module enemy_movement #(
    parameter int ENEMY_STEP = 2
) (
    input  logic                             clk,
    input  logic                             resetN,
    input  logic                             start_of_frame,
    input  logic                             hit,
    output logic [game_pkg::PIXEL_WIDTH-1:0] enemy_x
);
    import game_pkg::*;

    // widened so that x plus a step never wraps before the compare
    localparam int CW = PIXEL_WIDTH + 1;

    localparam logic [CW-1:0] STEP_W = CW'(ENEMY_STEP);
    localparam logic [CW-1:0] X_MAX  = CW'(SCREEN_W - ENEMY_W);

    // high while the enemy heads towards the right edge
    logic moving_right;

    logic [CW-1:0] x_wide;
    logic [CW-1:0] x_right;

    assign x_wide  = CW'(enemy_x);
    assign x_right = x_wide + STEP_W;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            enemy_x      <= '0;
            moving_right <= 1'b1;
        end else if (hit) begin
            // a destroyed enemy comes back at the left edge
            enemy_x      <= '0;
            moving_right <= 1'b1;
        end else if (start_of_frame) begin
            if (moving_right) begin
                if (x_right >= X_MAX) begin
                    // park on the right edge and turn round for the next frame
                    enemy_x      <= PIXEL_WIDTH'(X_MAX);
                    moving_right <= 1'b0;
                end else begin
                    enemy_x <= PIXEL_WIDTH'(x_right);
                end
            end else begin
                if (x_wide <= STEP_W) begin
                    // same on the left side
                    enemy_x      <= '0;
                    moving_right <= 1'b1;
                end else begin
                    enemy_x <= PIXEL_WIDTH'(x_wide - STEP_W);
                end
            end
        end
    end

endmodule

// ==== verilog/missile_movement.sv ====
module missile_movement #(
    parameter int MISSILE_SPEED = 512
) (
    input  logic                             clk,
    input  logic                             resetN,
    input  logic                             start_of_frame,
    input  logic                             fire_key,
    input  logic                             hit,
    input  logic [game_pkg::PIXEL_WIDTH-1:0] ship_x,
    output logic [game_pkg::PIXEL_WIDTH-1:0] missile_x,
    output logic [game_pkg::PIXEL_WIDTH-1:0] missile_y,
    output logic                             missile_active
);
    import game_pkg::*;

    // fixed-point width, whole pixels on top and fractions below
    localparam int FP_W = PIXEL_WIDTH + FIXED_SHIFT;

    localparam logic [FP_W-1:0] SPEED_FP = FP_W'(MISSILE_SPEED);

    // the missile starts with its bottom edge on the ship's top row
    localparam logic [FP_W-1:0] LAUNCH_Y_FP = FP_W'(SHIP_Y - MISSILE_H) << FIXED_SHIFT;

    missile_state_t state;

    logic [FP_W-1:0]        x_fp;
    logic [FP_W-1:0]        y_fp;
    logic [PIXEL_WIDTH-1:0] launch_x;

    // the missile is centred on the ship at the moment of launch
    assign launch_x = ship_x + PIXEL_WIDTH'(MISSILE_X_OFFSET);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state <= MISSILE_IDLE;
            x_fp  <= '0;
            y_fp  <= '0;
        end else if (hit) begin
            // a hit wins over everything and parks the missile at the origin
            state <= MISSILE_IDLE;
            x_fp  <= '0;
            y_fp  <= '0;
        end else begin
            case (state)
                MISSILE_IDLE: begin
                    // the key is caught on any cycle, not only on frame pulses
                    if (fire_key) begin
                        state <= MISSILE_ARMED;
                    end
                end
                MISSILE_ARMED: begin
                    if (start_of_frame) begin
                        state <= MISSILE_FLYING;
                        x_fp  <= FP_W'(launch_x) << FIXED_SHIFT;
                        y_fp  <= LAUNCH_Y_FP;
                    end
                end
                MISSILE_FLYING: begin
                    // fire_key is not looked at here, one missile at a time
                    if (start_of_frame) begin
                        if (y_fp < SPEED_FP) begin
                            // the next step would pass the top edge
                            state <= MISSILE_IDLE;
                            x_fp  <= '0;
                            y_fp  <= '0;
                        end else begin
                            y_fp <= y_fp - SPEED_FP;
                        end
                    end
                end
                default: begin
                    state <= MISSILE_IDLE;
                end
            endcase
        end
    end

    // drop the fraction bits to get whole pixels
    assign missile_x = PIXEL_WIDTH'(x_fp >> FIXED_SHIFT);
    assign missile_y = PIXEL_WIDTH'(y_fp >> FIXED_SHIFT);

    assign missile_active = (state == MISSILE_FLYING);

    // the hit comes from the scoring block a cycle after the frame pulse,
    // it only ever belongs to a flying missile, and that missile is back in idle next cycle
    idle_after_hit: assert property (
        @(posedge clk) disable iff (!resetN)
        hit |=> ($past(state) == MISSILE_FLYING) && (state == MISSILE_IDLE)
    ) else $error("hit for a missile that was not flying, or missile not idle after hit");

endmodule

// ==== verilog/ship_movement.sv ====
module ship_movement #(
    parameter int SHIP_STEP = 4
) (
    input  logic                             clk,
    input  logic                             resetN,
    input  logic                             start_of_frame,
    input  logic                             left_key,
    input  logic                             right_key,
    output logic [game_pkg::PIXEL_WIDTH-1:0] ship_x
);
    import game_pkg::*;

    // one extra bit so that the step to the right cannot overflow
    localparam int CW = PIXEL_WIDTH + 1;

    localparam logic [CW-1:0] STEP_W = CW'(SHIP_STEP);
    localparam logic [CW-1:0] X_MAX  = CW'(SCREEN_W - SHIP_W);

    // the ship starts in the middle of the screen
    localparam logic [PIXEL_WIDTH-1:0] X_RESET = PIXEL_WIDTH'((SCREEN_W - SHIP_W) / 2);

    logic [CW-1:0] x_wide;
    logic [CW-1:0] x_right;

    assign x_wide  = CW'(ship_x);
    assign x_right = x_wide + STEP_W;

    // the ship moves only on a frame pulse and only when exactly one key is held
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            ship_x <= X_RESET;
        end else if (start_of_frame) begin
            if (left_key && !right_key) begin
                // stop at the left edge rather than wrap around
                if (x_wide < STEP_W) begin
                    ship_x <= '0;
                end else begin
                    ship_x <= PIXEL_WIDTH'(x_wide - STEP_W);
                end
            end else if (right_key && !left_key) begin
                // the right limit keeps the whole ship box on screen
                if (x_right > X_MAX) begin
                    ship_x <= PIXEL_WIDTH'(X_MAX);
                end else begin
                    ship_x <= PIXEL_WIDTH'(x_right);
                end
            end
        end
    end

    // the missile launch point and the hit box both rely on this limit
    ship_in_screen: assert property (
        @(posedge clk) disable iff (!resetN)
        x_wide <= X_MAX
    ) else $error("ship_x beyond right limit: %0d", ship_x);

endmodule

// ==== verilog/game_pkg.sv ====
package game_pkg;

    // every screen coordinate in the game fits in this many bits
    localparam int PIXEL_WIDTH = 11;

    // positions that move in sub-pixel steps keep this many fractional bits
    // so one pixel is 64 fixed-point units
    localparam int FIXED_SHIFT = 6;

    // visible screen area in pixels
    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    // object boxes in pixels, measured from the top left corner
    localparam int SHIP_W    = 32;
    localparam int ENEMY_W   = 32;
    localparam int ENEMY_H   = 16;
    localparam int MISSILE_W = 4;
    localparam int MISSILE_H = 8;

    // the ship rides on a fixed row 40 pixels above the bottom edge
    localparam int SHIP_Y = SCREEN_H - 40;

    // shift from the ship's left edge that puts the missile in its middle
    localparam int MISSILE_X_OFFSET = 14;

    // the enemy sweeps along this fixed row near the top of the screen
    localparam int ENEMY_Y = 40;

    // idle waits for the fire key, armed waits for the next frame,
    // flying moves up each frame until the ceiling or a hit
    typedef enum logic [1:0] {
        MISSILE_IDLE,
        MISSILE_ARMED,
        MISSILE_FLYING
    } missile_state_t;

    // score saturates, it never wraps back to zero
    typedef logic [7:0] score_t;

endpackage
